// ==== blimp_core.f ====
+incdir+tests
logic/blimp_pkg.sv
logic/fetch_unit.sv
logic/decode_issue_unit.sv
logic/alu_unit.sv
logic/pipelined_multiplier.sv
logic/writeback_commit_unit.sv
logic/blimp_core.sv
tests/blimp_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it, and scan the log for failures
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f blimp_core.f \
  --top-module blimp_core_tb -o blimp_sim \
  && ./obj_dir/blimp_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== tests/blimp_tb_model.svh ====
// Program generator, RV32 encoders and in-order ISA reference model
`ifndef BLIMP_TB_MODEL_SVH
`define BLIMP_TB_MODEL_SVH

// R-type with funct3 zero, ADD or MUL by funct7
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [4:0] rd);
  return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
endfunction

// I-type ADDI
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [4:0] rd);
  return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

// Seeding ADDIs for x0..x7, then random ADD, ADDI and MUL over the same regs
task automatic gen_program();
  int          kind;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  prev_rd;
  logic [11:0] imm;
  prev_rd = 5'd0;
  for (int i = 0; i < n_seed; i++) begin
    imm    = 12'($random(seed));
    mem[i] = enc_i(imm, 5'd0, 5'(i));   // x0 too, commits with wen low
  end
  for (int i = n_seed; i < n_total; i++) begin
    kind = {$random(seed)} % 3;
    rd   = 5'({$random(seed)} % 8);
    rs1  = 5'({$random(seed)} % 8);
    rs2  = 5'({$random(seed)} % 8);
    imm  = 12'($random(seed));          // Full signed range
    if ({$random(seed)} % 3 == 0) rs1 = prev_rd; // Reads the previous result
    case (kind)
      0:       mem[i] = enc_r(7'b0000000, rs2, rs1, rd);
      1:       mem[i] = enc_i(imm, rs1, rd);
      default: mem[i] = enc_r(7'b0000001, rs2, rs1, rd);
    endcase
    prev_rd = rd;
  end
endtask

// In-order execution, one expected trace record per instruction
task automatic run_model();
  logic [31:0] regs [32];
  logic [31:0] inst;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm;
  logic [31:0] res;
  logic [4:0]  rd;
  for (int r = 0; r < 32; r++) regs[r] = 32'd0;
  for (int i = 0; i < n_total; i++) begin
    inst = mem[i];
    rd   = inst[11:7];
    a    = regs[inst[19:15]];           // regs[0] stays zero
    b    = regs[inst[24:20]];
    imm  = {{20{inst[31]}}, inst[31:20]};
    if (inst[6:0] == 7'b0010011) res = a + imm;
    else if (inst[31:25] == 7'b0000001) res = a * b; // Low word of product
    else res = a + b;
    if (rd != 5'd0) regs[rd] = res;
    exp_pc.push_back(32'(i * 4));       // Straight-line code
    exp_waddr.push_back(rd);
    exp_wen.push_back(rd != 5'd0);
    exp_wdata.push_back(res);
  end
endtask

`endif

// ==== tests/blimp_core_tb.sv ====
// Core testbench with clock, reset, instruction memory model, trace checks and watchdog
`timescale 1ns/1ps

module blimp_core_tb;

  localparam int n_seed         = 8;           // ADDIs for x0..x7
  localparam int n_random       = 200;
  localparam int n_total        = n_seed + n_random;
  localparam int clk_period     = 40;
  localparam int timeout_cycles = n_random * 40;

  logic        clk = 1'b0;
  logic        rst;
  logic        imem_req_val;
  logic [31:0] imem_req_addr;
  logic        imem_req_rdy;
  logic        imem_resp_val;
  logic [31:0] imem_resp_data;
  logic        trace_val;
  logic [31:0] trace_pc;
  logic [4:0]  trace_waddr;
  logic [31:0] trace_wdata;
  logic        trace_wen;

  integer      seed = 32'hea41;
  logic [31:0] mem [n_total];                  // Program image
  logic [31:0] exp_pc[$];
  logic [31:0] exp_wdata[$];
  logic [4:0]  exp_waddr[$];
  logic        exp_wen[$];

  int pc_errs, waddr_errs, wen_errs, wdata_errs, other_errs;
  int commits;
  int          wait_cnt;                       // Cycles to the response
  logic [31:0] resp_addr;
  logic [31:0] next_addr;
  logic        seen_req;

  `include "blimp_tb_model.svh"

  // Multiplier deeper than the fetch period so a later ADD can finish first
  blimp_core #(
    .p_seq_num_bits (5),
    .p_mul_stages   (8)
  ) DUT (
    .clk            (clk),
    .rst            (rst),
    .imem_req_val   (imem_req_val),
    .imem_req_addr  (imem_req_addr),
    .imem_req_rdy   (imem_req_rdy),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_data (imem_resp_data),
    .trace_val      (trace_val),
    .trace_pc       (trace_pc),
    .trace_waddr    (trace_waddr),
    .trace_wdata    (trace_wdata),
    .trace_wen      (trace_wen)
  );

  always #(clk_period / 2) clk = ~clk;

  // --------------------------------------------------
  // Instruction memory model
  // --------------------------------------------------

  always @(posedge clk) begin
    // Address the core shows next cycle since its PC moves only on accept
    next_addr = (imem_req_val && imem_req_rdy) ? imem_req_addr + 32'd4 : imem_req_addr;
    if (rst) begin
      imem_req_rdy  <= 1'b0;
      imem_resp_val <= 1'b0;
      wait_cnt      <= 0;
      seen_req      <= 1'b0;
    end else begin
      // Random stalls, and nothing past the last instruction
      imem_req_rdy  <= ({$random(seed)} % 4 != 0) && (next_addr < 32'(n_total * 4));
      imem_resp_val <= 1'b0;
      if (imem_req_val && imem_req_rdy) begin
        assert (seen_req || imem_req_addr == 32'd0) else begin
          other_errs++;
          $display("[ERROR] first request: expected %h, actual %h", 32'd0, imem_req_addr);
        end
        seen_req  <= 1'b1;
        resp_addr <= imem_req_addr;
        wait_cnt  <= 1 + int'({$random(seed)} % 4); // 1 to 4 cycles
      end else if (wait_cnt == 1) begin
        imem_resp_val  <= 1'b1;
        imem_resp_data <= mem[resp_addr[31:2]];
        wait_cnt       <= 0;
      end else if (wait_cnt > 1) begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  // --------------------------------------------------
  // Trace checking
  // --------------------------------------------------

  task automatic show_mismatch(input string name, input logic [31:0] exp, act);
    $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
  endtask

  // Next expected record against the trace port
  task automatic check_commit();
    logic [31:0] e_pc;
    logic [31:0] e_wdata;
    logic [4:0]  e_waddr;
    logic        e_wen;
    e_pc    = exp_pc.pop_front();
    e_wdata = exp_wdata.pop_front();
    e_waddr = exp_waddr.pop_front();
    e_wen   = exp_wen.pop_front();
    assert (trace_pc === e_pc) else begin
      pc_errs++;
      show_mismatch($sformatf("commit %0d pc", commits), e_pc, trace_pc);
    end
    assert (trace_waddr === e_waddr) else begin
      waddr_errs++;
      show_mismatch($sformatf("waddr at pc %h", e_pc), 32'(e_waddr), 32'(trace_waddr));
    end
    assert (trace_wen === e_wen) else begin
      wen_errs++;
      show_mismatch($sformatf("wen at pc %h", e_pc), 32'(e_wen), 32'(trace_wen));
    end
    if (e_wen) begin
      assert (trace_wdata === e_wdata) else begin
        wdata_errs++;
        show_mismatch($sformatf("wdata at pc %h", e_pc), e_wdata, trace_wdata);
      end
    end
    commits++;
  endtask

  // Sample mid-cycle once outputs have settled
  always @(negedge clk) begin
    if (rst) begin
      assert (trace_val !== 1'b1) else begin
        other_errs++;
        $display("Trace valid seen while reset was asserted");
      end
    end else if (trace_val === 1'b1) begin
      assert (exp_pc.size() > 0) else begin
        other_errs++;
        $display("Extra commit at pc %h after the whole program committed", trace_pc);
      end
      if (exp_pc.size() > 0) check_commit();
    end
  end

  // --------------------------------------------------
  // Sequence, watchdog and summary
  // --------------------------------------------------

  initial begin
    rst            = 1'b1;
    imem_req_rdy   = 1'b0;
    imem_resp_val  = 1'b0;
    imem_resp_data = 32'd0;
    gen_program();
    run_model();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    wait (commits == n_total);
    repeat (20) @(posedge clk);                // Room for stray commits
    $display("Error counts: pc %0d, waddr %0d, wen %0d, wdata %0d, other %0d",
             pc_errs, waddr_errs, wen_errs, wdata_errs, other_errs);
    if (pc_errs + waddr_errs + wen_errs + wdata_errs + other_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(timeout_cycles * clk_period);
    $display("Timeout after %0d cycles, %0d of %0d commits missing",
             timeout_cycles, n_total - commits, n_total);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== logic/blimp_core.sv ====
// Blimp core top level wiring fetch, decode-issue, execute pipes and commit
`timescale 1ns/1ps

module blimp_core #(
  parameter int p_seq_num_bits = 5,
  parameter int p_mul_stages   = 4
) (
  input  logic                clk,
  input  logic                rst,
  // Instruction memory
  output logic                imem_req_val,
  output blimp_pkg::addr_t    imem_req_addr,
  input  logic                imem_req_rdy,
  input  logic                imem_resp_val,
  input  blimp_pkg::word_t    imem_resp_data,
  // Instruction trace
  output logic                trace_val,
  output blimp_pkg::addr_t    trace_pc,
  output blimp_pkg::reg_idx_t trace_waddr,
  output blimp_pkg::word_t    trace_wdata,
  output logic                trace_wen
);

  import blimp_pkg::*;

  // --------------------------------------------------
  // Inter-unit wires
  // --------------------------------------------------

  // Fetch to decode
  logic  f_val, f_rdy;
  word_t f_inst;
  addr_t f_pc;

  // Decode to ALU and back
  logic                      alu_val, alu_rdy, alu_wen;
  logic [p_seq_num_bits-1:0] alu_seq;
  reg_idx_t                  alu_waddr;
  addr_t                     alu_pc;
  word_t                     alu_op_a, alu_op_b;
  logic                      alu_w_val, alu_w_wen;
  logic [p_seq_num_bits-1:0] alu_w_seq;
  reg_idx_t                  alu_w_waddr;
  addr_t                     alu_w_pc;
  word_t                     alu_w_data;

  // Decode to multiplier and back
  logic                      mul_val, mul_rdy, mul_wen;
  logic [p_seq_num_bits-1:0] mul_seq;
  reg_idx_t                  mul_waddr;
  addr_t                     mul_pc;
  word_t                     mul_op_a, mul_op_b;
  logic                      mul_w_val, mul_w_wen;
  logic [p_seq_num_bits-1:0] mul_w_seq;
  reg_idx_t                  mul_w_waddr;
  addr_t                     mul_w_pc;
  word_t                     mul_w_data;

  // Commit
  logic     cm_val, cm_wen;
  addr_t    cm_pc;
  reg_idx_t cm_waddr;
  word_t    cm_wdata;

  assign trace_val   = cm_val;
  assign trace_pc    = cm_pc;
  assign trace_waddr = cm_waddr;
  assign trace_wdata = cm_wdata;
  assign trace_wen   = cm_wen;

  // --------------------------------------------------
  // Units
  // --------------------------------------------------

  fetch_unit fu (.*);

  decode_issue_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) diu (.*);

  alu_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) alu_xu (.*);

  pipelined_multiplier #(
    .p_seq_num_bits (p_seq_num_bits),
    .p_mul_stages   (p_mul_stages)
  ) mul_xu (.*);

  writeback_commit_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) wcu (
    .cm_seq (),   // Only the ROB tracks it
    .*
  );

endmodule

// ==== logic/writeback_commit_unit.sv ====
// Writeback-commit unit with sequence-indexed reorder buffer and in-order commit
`timescale 1ns/1ps

module writeback_commit_unit #(
  parameter int p_seq_num_bits = 5
) (
  input  logic                      clk,
  input  logic                      rst,
  // ALU completions
  input  logic                      alu_w_val,
  input  logic [p_seq_num_bits-1:0] alu_w_seq,
  input  blimp_pkg::reg_idx_t       alu_w_waddr,
  input  logic                      alu_w_wen,
  input  blimp_pkg::addr_t          alu_w_pc,
  input  blimp_pkg::word_t          alu_w_data,
  // Multiplier completions
  input  logic                      mul_w_val,
  input  logic [p_seq_num_bits-1:0] mul_w_seq,
  input  blimp_pkg::reg_idx_t       mul_w_waddr,
  input  logic                      mul_w_wen,
  input  blimp_pkg::addr_t          mul_w_pc,
  input  blimp_pkg::word_t          mul_w_data,
  // Commit
  output logic                      cm_val,
  output blimp_pkg::addr_t          cm_pc,
  output blimp_pkg::reg_idx_t       cm_waddr,
  output blimp_pkg::word_t          cm_wdata,
  output logic                      cm_wen,
  output logic [p_seq_num_bits-1:0] cm_seq
);

  import blimp_pkg::*;

  localparam int rob_entries = 2 ** p_seq_num_bits;

  logic [rob_entries-1:0]    done;     // Result present
  logic [rob_entries-1:0]    rob_wen;
  addr_t                     rob_pc    [rob_entries];
  reg_idx_t                  rob_waddr [rob_entries];
  word_t                     rob_data  [rob_entries];
  logic [p_seq_num_bits-1:0] head;     // Oldest uncommitted

  // --------------------------------------------------
  // Commit port
  // --------------------------------------------------

  assign cm_val   = done[head];        // Earliest one cycle after the strobe
  assign cm_pc    = rob_pc[head];
  assign cm_waddr = rob_waddr[head];
  assign cm_wdata = rob_data[head];
  assign cm_wen   = rob_wen[head];
  assign cm_seq   = head;

  always_ff @(posedge clk) begin
    if (rst) begin
      done <= '0;
      head <= '0;
    end else begin
      if (cm_val) begin
        done[head] <= 1'b0;            // Free the slot
        head       <= head + 1'b1;
      end
      // Completing seqs are never the head
      if (alu_w_val) done[alu_w_seq] <= 1'b1;
      if (mul_w_val) done[mul_w_seq] <= 1'b1;
    end
  end

  // Entry payload, both pipes in one cycle
  always_ff @(posedge clk) begin
    if (alu_w_val) begin
      rob_pc[alu_w_seq]    <= alu_w_pc;
      rob_waddr[alu_w_seq] <= alu_w_waddr;
      rob_wen[alu_w_seq]   <= alu_w_wen;
      rob_data[alu_w_seq]  <= alu_w_data;
    end
    if (mul_w_val) begin
      rob_pc[mul_w_seq]    <= mul_w_pc;
      rob_waddr[mul_w_seq] <= mul_w_waddr;
      rob_wen[mul_w_seq]   <= mul_w_wen;
      rob_data[mul_w_seq]  <= mul_w_data;
    end
  end

endmodule

// ==== logic/pipelined_multiplier.sv ====
// Multiplier pipe of configurable depth carrying sequence and destination tags
`timescale 1ns/1ps

module pipelined_multiplier #(
  parameter int p_seq_num_bits = 5,
  parameter int p_mul_stages   = 4
) (
  input  logic                      clk,
  input  logic                      rst,
  // From decode
  input  logic                      mul_val,
  output logic                      mul_rdy,
  input  logic [p_seq_num_bits-1:0] mul_seq,
  input  blimp_pkg::reg_idx_t       mul_waddr,
  input  logic                      mul_wen,
  input  blimp_pkg::addr_t          mul_pc,
  input  blimp_pkg::word_t          mul_op_a,
  input  blimp_pkg::word_t          mul_op_b,
  // To writeback
  output logic                      mul_w_val,
  output logic [p_seq_num_bits-1:0] mul_w_seq,
  output blimp_pkg::reg_idx_t       mul_w_waddr,
  output logic                      mul_w_wen,
  output blimp_pkg::addr_t          mul_w_pc,
  output blimp_pkg::word_t          mul_w_data
);

  import blimp_pkg::*;

  localparam int last = p_mul_stages - 1;

  word_t product;

  // Stage registers
  logic [p_mul_stages-1:0]   vld;
  logic [p_mul_stages-1:0]   wen_q;
  logic [p_seq_num_bits-1:0] seq_q   [p_mul_stages];
  reg_idx_t                  waddr_q [p_mul_stages];
  addr_t                     pc_q    [p_mul_stages];
  word_t                     data_q  [p_mul_stages];

  assign mul_rdy = 1'b1;                  // Advances every cycle
  assign product = mul_op_a * mul_op_b;   // Low word only

  always_ff @(posedge clk) begin
    if (rst) begin
      vld <= '0;
    end else begin
      vld[0] <= mul_val;
      for (int i = 1; i < p_mul_stages; i++) vld[i] <= vld[i-1];
    end
  end

  // Shift chain for result and tags
  always_ff @(posedge clk) begin
    seq_q[0]   <= mul_seq;
    waddr_q[0] <= mul_waddr;
    wen_q[0]   <= mul_wen;
    pc_q[0]    <= mul_pc;
    data_q[0]  <= product;
    for (int i = 1; i < p_mul_stages; i++) begin
      seq_q[i]   <= seq_q[i-1];
      waddr_q[i] <= waddr_q[i-1];
      wen_q[i]   <= wen_q[i-1];
      pc_q[i]    <= pc_q[i-1];
      data_q[i]  <= data_q[i-1];
    end
  end

  // Tail of the chain
  assign mul_w_val   = vld[last];
  assign mul_w_seq   = seq_q[last];
  assign mul_w_waddr = waddr_q[last];
  assign mul_w_wen   = wen_q[last];
  assign mul_w_pc    = pc_q[last];
  assign mul_w_data  = data_q[last];

endmodule

// ==== logic/alu_unit.sv ====
// One-cycle adder pipe for ADD and ADDI
`timescale 1ns/1ps

module alu_unit #(
  parameter int p_seq_num_bits = 5
) (
  input  logic                      clk,
  input  logic                      rst,
  // From decode
  input  logic                      alu_val,
  output logic                      alu_rdy,
  input  logic [p_seq_num_bits-1:0] alu_seq,
  input  blimp_pkg::reg_idx_t       alu_waddr,
  input  logic                      alu_wen,
  input  blimp_pkg::addr_t          alu_pc,
  input  blimp_pkg::word_t          alu_op_a,
  input  blimp_pkg::word_t          alu_op_b,
  // To writeback
  output logic                      alu_w_val,
  output logic [p_seq_num_bits-1:0] alu_w_seq,
  output blimp_pkg::reg_idx_t       alu_w_waddr,
  output logic                      alu_w_wen,
  output blimp_pkg::addr_t          alu_w_pc,
  output blimp_pkg::word_t          alu_w_data
);

  import blimp_pkg::*;

  word_t sum;

  assign alu_rdy = 1'b1;               // Never stalls
  assign sum     = alu_op_a + alu_op_b; // Wraps at 32 bits

  always_ff @(posedge clk) begin
    if (rst) alu_w_val <= 1'b0;
    else     alu_w_val <= alu_val;
  end

  // Result and tags
  always_ff @(posedge clk) begin
    alu_w_seq   <= alu_seq;
    alu_w_waddr <= alu_waddr;
    alu_w_wen   <= alu_wen;
    alu_w_pc    <= alu_pc;
    alu_w_data  <= sum;
  end

endmodule

// ==== logic/decode_issue_unit.sv ====
// Decode-issue unit with register file, scoreboard, sequence numbers and routing
`timescale 1ns/1ps

module decode_issue_unit #(
  parameter int p_seq_num_bits = 5
) (
  input  logic                      clk,
  input  logic                      rst,
  // Fetch side
  input  logic                      f_val,
  input  blimp_pkg::word_t          f_inst,
  input  blimp_pkg::addr_t          f_pc,
  output logic                      f_rdy,
  // ALU side
  output logic                      alu_val,
  input  logic                      alu_rdy,
  output logic [p_seq_num_bits-1:0] alu_seq,
  output blimp_pkg::reg_idx_t       alu_waddr,
  output logic                      alu_wen,
  output blimp_pkg::addr_t          alu_pc,
  output blimp_pkg::word_t          alu_op_a,
  output blimp_pkg::word_t          alu_op_b,
  // Multiplier side
  output logic                      mul_val,
  input  logic                      mul_rdy,
  output logic [p_seq_num_bits-1:0] mul_seq,
  output blimp_pkg::reg_idx_t       mul_waddr,
  output logic                      mul_wen,
  output blimp_pkg::addr_t          mul_pc,
  output blimp_pkg::word_t          mul_op_a,
  output blimp_pkg::word_t          mul_op_b,
  // Commit side
  input  logic                      cm_val,
  input  blimp_pkg::reg_idx_t       cm_waddr,
  input  blimp_pkg::word_t          cm_wdata,
  input  logic                      cm_wen
);

  import blimp_pkg::*;

  localparam int rob_entries = 2 ** p_seq_num_bits;

  issue_state_t state;
  word_t        d_inst;      // Held instruction
  addr_t        d_pc;

  word_t rf [32];            // Architectural registers
  logic [31:0] sb;           // Pending write per register
  logic [p_seq_num_bits:0]   in_flight;
  logic [p_seq_num_bits-1:0] next_seq;

  opcode_t   opcode;
  funct3_t   funct3;
  funct7_t   funct7;
  reg_idx_t  rd, rs1, rs2;
  word_t     imm_i, rs1_data, rs2_data, op_b;
  logic      is_op, is_add, is_mul, is_addi, legal, d_wen;
  logic      hazard, rob_full, tgt_rdy, issue;
  pipe_sel_t sel;

  // --------------------------------------------------
  // Decode and operand read
  // --------------------------------------------------

  assign opcode = d_inst[6:0];
  assign rd     = d_inst[11:7];
  assign funct3 = d_inst[14:12];
  assign rs1    = d_inst[19:15];
  assign rs2    = d_inst[24:20];
  assign funct7 = d_inst[31:25];
  assign imm_i  = {{20{d_inst[31]}}, d_inst[31:20]}; // Sign-extended

  assign is_op   = (opcode == OPC_OP) && (funct3 == F3_ADD);
  assign is_add  = is_op && (funct7 == F7_ADD);
  assign is_mul  = is_op && (funct7 == F7_MUL);
  assign is_addi = (opcode == OPC_OP_IMM) && (funct3 == F3_ADD);
  assign legal   = is_add || is_mul || is_addi;
  assign sel     = is_mul ? PIPE_MUL : PIPE_ALU;    // Anything else rides the ALU
  assign d_wen   = legal && (rd != '0);             // x0 and unknowns write nothing

  assign rs1_data = (rs1 == '0) ? '0 : rf[rs1];     // x0 reads zero
  assign rs2_data = (rs2 == '0) ? '0 : rf[rs2];
  assign op_b     = is_op ? rs2_data : imm_i;

  // Issue conditions
  assign hazard   = sb[rs1] || (is_op && sb[rs2]) || sb[rd];
  assign rob_full = (in_flight == rob_entries[p_seq_num_bits:0]);
  assign tgt_rdy  = (sel == PIPE_MUL) ? mul_rdy : alu_rdy;
  assign issue    = (state != IDLE) && !hazard && !rob_full && tgt_rdy;
  assign f_rdy    = (state == IDLE) || issue;       // Refill as we send

  // --------------------------------------------------
  // Routing to the pipes
  // --------------------------------------------------

  assign alu_val   = issue && (sel == PIPE_ALU);
  assign alu_seq   = next_seq;
  assign alu_waddr = rd;
  assign alu_wen   = d_wen;
  assign alu_pc    = d_pc;
  assign alu_op_a  = rs1_data;
  assign alu_op_b  = op_b;

  assign mul_val   = issue && (sel == PIPE_MUL);
  assign mul_seq   = next_seq;
  assign mul_waddr = rd;
  assign mul_wen   = d_wen;
  assign mul_pc    = d_pc;
  assign mul_op_a  = rs1_data;
  assign mul_op_b  = op_b;

  // --------------------------------------------------
  // FSM, scoreboard and counters
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      sb        <= '0;
      in_flight <= '0;
      next_seq  <= '0;
    end else begin
      if (f_val && f_rdy) state <= SEND;
      else if (issue)     state <= IDLE;
      else if (state != IDLE) state <= STALL; // Hazard or full ROB

      if (cm_val && cm_wen) sb[cm_waddr] <= 1'b0;
      if (issue && d_wen)   sb[rd]       <= 1'b1; // Never the same reg as above

      case ({issue, cm_val})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase

      if (issue) next_seq <= next_seq + 1'b1; // Wraps with the ROB
    end
  end

  // Held instruction and register file writes
  always_ff @(posedge clk) begin
    if (f_val && f_rdy) begin
      d_inst <= f_inst;
      d_pc   <= f_pc;
    end
    if (cm_val && cm_wen) rf[cm_waddr] <= cm_wdata;
  end

endmodule

// ==== logic/fetch_unit.sv ====
// Fetch unit with PC, instruction memory request/response and decode buffer
`timescale 1ns/1ps

module fetch_unit (
  input  logic             clk,
  input  logic             rst,
  // Instruction memory
  output logic             imem_req_val,
  output blimp_pkg::addr_t imem_req_addr,
  input  logic             imem_req_rdy,
  input  logic             imem_resp_val,
  input  blimp_pkg::word_t imem_resp_data,
  // Toward decode
  output logic             f_val,
  output blimp_pkg::word_t f_inst,
  output blimp_pkg::addr_t f_pc,
  input  logic             f_rdy
);

  import blimp_pkg::*;

  addr_t pc;      // Address of the next request
  logic  pending; // Accepted, response not back yet

  assign imem_req_addr = pc;

  // --------------------------------------------------
  // Request and buffer control
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pc           <= '0;
      pending      <= 1'b0;
      imem_req_val <= 1'b0;
      f_val        <= 1'b0;
    end else begin
      if (imem_req_val && imem_req_rdy) begin
        imem_req_val <= 1'b0;
        pending      <= 1'b1;
        pc           <= pc + 32'd4; // Straight-line code only
      end else if (!imem_req_val && !pending && !f_val) begin
        imem_req_val <= 1'b1;       // Buffer free, ask again
      end

      // One-entry buffer toward decode
      if (pending && imem_resp_val) begin
        pending <= 1'b0;
        f_val   <= 1'b1;
      end else if (f_val && f_rdy) begin
        f_val <= 1'b0;              // Taken by decode
      end
    end
  end

  // Response capture
  always_ff @(posedge clk) begin
    if (pending && imem_resp_val) begin
      f_inst <= imem_resp_data;
      f_pc   <= pc - 32'd4;         // PC already stepped past it
    end
  end

endmodule

// ==== logic/blimp_pkg.sv ====
// Blimp widths, instruction field types, opcode constants and issue states
package blimp_pkg;

  // Datapath widths
  typedef logic [31:0] word_t;    // Data or instruction word
  typedef logic [31:0] addr_t;    // Byte address
  typedef logic [4:0]  reg_idx_t; // Architectural register

  // Instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // --------------------------------------------------
  // RV32 encodings for ADD, ADDI and MUL
  // --------------------------------------------------

  localparam opcode_t OPC_OP     = 7'b0110011; // Register-register class
  localparam opcode_t OPC_OP_IMM = 7'b0010011; // Register-immediate class
  localparam funct3_t F3_ADD     = 3'b000;     // Shared by all three
  localparam funct7_t F7_ADD     = 7'b0000000;
  localparam funct7_t F7_MUL     = 7'b0000001; // M extension

  // Target execute pipe
  typedef enum logic {
    PIPE_ALU,
    PIPE_MUL
  } pipe_sel_t;

  // Decode-issue FSM
  typedef enum logic [1:0] {
    IDLE,  // Nothing held
    STALL, // Held behind a hazard
    SEND   // Freshly captured
  } issue_state_t;

endpackage
